//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I2C master testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_i2c_master \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

//--- src/i2c_bit_ctrl.sv
`timescale 1ns/1ps

module i2c_bit_ctrl (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              bit_go,     // Start one bit command
    input  i2c_pkg::bit_req_t bit_req,
    input  logic              tick,       // Quarter period strobe
    input  logic              sda_in,     // SDA pad read-back
    output logic              tick_en,
    output logic              bit_done,   // One cycle after the fourth tick
    output logic              dout,       // Sampled SDA
    output logic              scl_oe,     // 1 pulls SCL low
    output logic              sda_oe      // 1 pulls SDA low
);

    import i2c_pkg::*;

    bit_req_t   cur;      // Command in flight
    logic       active;
    logic [1:0] phase;    // Quarter within the bit

    assign tick_en = active;  // Divider runs only during a command

    // --------------------
    // Phase sequencing
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active   <= 1'b0;
            phase    <= 2'd0;
            bit_done <= 1'b0;
            dout     <= 1'b0;
            scl_oe   <= 1'b0;   // Both lines released
            sda_oe   <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (bit_go) begin
                active <= 1'b1;
                phase  <= 2'd0;
                // Phase 0 entry actions
                case (bit_req.cmd)
                    BIT_START: sda_oe <= 1'b0;  // SDA released first
                    default:   scl_oe <= 1'b1;  // SCL low before SDA moves
                endcase
            end else if (active) begin
                // Data set one cycle after SCL went low
                if (phase == 2'd0 && cur.cmd == BIT_WRITE) begin
                    sda_oe <= ~cur.din;
                end
                if (phase == 2'd0 && cur.cmd == BIT_READ) begin
                    sda_oe <= 1'b0;     // Let the slave drive
                end

                if (tick) begin
                    phase <= phase + 2'd1;
                    case (cur.cmd)
                        BIT_START: begin
                            case (phase)
                                2'd0:    scl_oe <= 1'b0;  // SCL high
                                2'd1:    sda_oe <= 1'b1;  // START edge
                                2'd2:    scl_oe <= 1'b1;  // SCL low
                                default: ;
                            endcase
                        end
                        BIT_STOP: begin
                            case (phase)
                                2'd0:    sda_oe <= 1'b1;  // SDA low under low SCL
                                2'd1:    scl_oe <= 1'b0;  // SCL high
                                2'd2:    sda_oe <= 1'b0;  // STOP edge
                                default: ;
                            endcase
                        end
                        default: begin
                            // Write and read share the clock shape
                            if (phase == 2'd1) begin
                                scl_oe <= 1'b0;           // Rising SCL
                            end
                            if (phase == 2'd2) begin
                                dout <= sda_in;           // Mid high period
                            end
                        end
                    endcase

                    if (phase == 2'd3) begin
                        active   <= 1'b0;
                        bit_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Command register holds until the next go
    always_ff @(posedge clk) begin
        if (bit_go) begin
            cur <= bit_req;
        end
    end

    // --------------------
    // Checks
    // --------------------
    // Sequencer keeps one command outstanding
    a_no_overlap : assert property (@(posedge clk) disable iff (!reset_n)
        bit_go |-> !active);

    // SDA moves under released SCL only as START or STOP
    a_sda_stable : assert property (@(posedge clk) disable iff (!reset_n)
        ($changed(sda_oe) && !scl_oe && !$past(scl_oe))
            |-> (cur.cmd inside {BIT_START, BIT_STOP}));

endmodule

//--- src/i2c_byte_ctrl.sv
`timescale 1ns/1ps
`include "i2c_settings.svh"

module i2c_byte_ctrl (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              load,       // Transaction strobe
    input  i2c_pkg::i2c_req_t req,
    input  logic              bit_done,
    input  logic              dout,       // Bit sampled by the bit engine
    output logic              busy,
    output logic              bit_go,
    output i2c_pkg::bit_req_t bit_req,
    output i2c_pkg::i2c_rsp_t rsp
);

    import i2c_pkg::*;

    seq_state_e state;
    i2c_req_t   req_q;      // Latched request
    logic [7:0] shreg;      // Outgoing bits MSB first, or incoming read bits
    logic [2:0] bit_cnt;    // Bits left after the current one
    logic       ack_err;
    logic [7:0] addr_byte;

    assign addr_byte = {`I2C_DEV_ADDR, req_q.rw};  // R/W in the LSB

    // --------------------
    // Transaction FSM
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= SEQ_IDLE;
            busy    <= 1'b0;
            bit_go  <= 1'b0;
            bit_req <= '{cmd: BIT_START, din: 1'b1};
            bit_cnt <= 3'd0;
            ack_err <= 1'b0;
            rsp     <= '0;
        end else begin
            bit_go <= 1'b0;  // Single cycle pulse
            case (state)
                SEQ_IDLE: begin
                    if (load) begin
                        busy    <= 1'b1;
                        ack_err <= 1'b0;
                        bit_go  <= 1'b1;
                        bit_req <= '{cmd: BIT_START, din: 1'b1};
                        state   <= SEQ_START;
                    end
                end

                SEQ_START: if (bit_done) begin
                    bit_go  <= 1'b1;
                    bit_req <= '{cmd: BIT_WRITE, din: addr_byte[7]};
                    bit_cnt <= 3'd7;
                    state   <= SEQ_ADDR;
                end

                SEQ_ADDR, SEQ_WRITE: if (bit_done) begin
                    bit_go <= 1'b1;
                    if (bit_cnt == 3'd0) begin
                        bit_req <= '{cmd: BIT_READ, din: 1'b1};  // ACK slot
                        state   <= (state == SEQ_ADDR) ? SEQ_ADDR_ACK : SEQ_WRITE_ACK;
                    end else begin
                        bit_req <= '{cmd: BIT_WRITE, din: shreg[7]};
                        bit_cnt <= bit_cnt - 3'd1;
                    end
                end

                SEQ_ADDR_ACK: if (bit_done) begin
                    bit_go  <= 1'b1;
                    bit_cnt <= 3'd7;
                    if (dout) begin
                        ack_err <= 1'b1;                      // No device answered
                        bit_req <= '{cmd: BIT_STOP, din: 1'b1};
                        state   <= SEQ_STOP;
                    end else if (req_q.rw) begin
                        bit_req <= '{cmd: BIT_READ, din: 1'b1};
                        state   <= SEQ_READ;
                    end else begin
                        bit_req <= '{cmd: BIT_WRITE, din: req_q.wdata[7]};
                        state   <= SEQ_WRITE;
                    end
                end

                SEQ_WRITE_ACK: if (bit_done) begin
                    ack_err <= dout;                          // High = NACK on data
                    bit_go  <= 1'b1;
                    bit_req <= '{cmd: BIT_STOP, din: 1'b1};
                    state   <= SEQ_STOP;
                end

                SEQ_READ: if (bit_done) begin
                    bit_go <= 1'b1;
                    if (bit_cnt == 3'd0) begin
                        bit_req <= '{cmd: BIT_WRITE, din: 1'b1};  // NACK ends the read
                        state   <= SEQ_READ_NACK;
                    end else begin
                        bit_req <= '{cmd: BIT_READ, din: 1'b1};
                        bit_cnt <= bit_cnt - 3'd1;
                    end
                end

                SEQ_READ_NACK: if (bit_done) begin
                    bit_go  <= 1'b1;
                    bit_req <= '{cmd: BIT_STOP, din: 1'b1};
                    state   <= SEQ_STOP;
                end

                SEQ_STOP: if (bit_done) begin
                    busy  <= 1'b0;
                    rsp   <= '{rdata: shreg, ack_error: ack_err};
                    state <= SEQ_IDLE;
                end

                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // --------------------
    // Data path
    // --------------------
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && load) begin
            req_q <= req;
        end
        if (bit_done) begin
            case (state)
                SEQ_START:    shreg <= {addr_byte[6:0], 1'b0};
                SEQ_ADDR_ACK: shreg <= {req_q.wdata[6:0], 1'b0};  // Unused on read
                SEQ_ADDR,
                SEQ_WRITE:    shreg <= {shreg[6:0], 1'b0};        // Empties to zero
                SEQ_READ:     shreg <= {shreg[6:0], dout};        // MSB arrives first
                default:      ;
            endcase
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_go_in_busy : assert property (@(posedge clk) disable iff (!reset_n)
        bit_go |-> busy);

    a_state_legal : assert property (@(posedge clk) disable iff (!reset_n)
        state inside {SEQ_IDLE, SEQ_START, SEQ_ADDR, SEQ_ADDR_ACK, SEQ_WRITE,
                      SEQ_WRITE_ACK, SEQ_READ, SEQ_READ_NACK, SEQ_STOP});

endmodule

//--- src/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              load,
    input  i2c_pkg::i2c_req_t req,
    output logic              busy,
    output i2c_pkg::i2c_rsp_t rsp,
    inout  wire               scl,
    inout  wire               sda
);

    import i2c_pkg::*;

    logic     tick_en;
    logic     tick;
    logic     bit_go;
    bit_req_t bit_req;
    logic     bit_done;
    logic     dout;
    logic     scl_oe;
    logic     sda_oe;
    logic     sda_in;

    // --------------------
    // Open-drain pads
    // --------------------
    assign scl    = scl_oe ? 1'b0 : 1'bz;   // Pull-up outside
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;                    // Read-back for ACK and data

    i2c_tick_gen u_tick_gen (
        .clk     (clk),
        .reset_n (reset_n),
        .tick_en (tick_en),
        .tick    (tick)
    );

    i2c_bit_ctrl u_bit_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .bit_go   (bit_go),
        .bit_req  (bit_req),
        .tick     (tick),
        .sda_in   (sda_in),
        .tick_en  (tick_en),
        .bit_done (bit_done),
        .dout     (dout),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe)
    );

    i2c_byte_ctrl u_byte_ctrl (
        .clk      (clk),
        .reset_n  (reset_n),
        .load     (load),
        .req      (req),
        .bit_done (bit_done),
        .dout     (dout),
        .busy     (busy),
        .bit_go   (bit_go),
        .bit_req  (bit_req),
        .rsp      (rsp)
    );

endmodule

//--- src/i2c_pkg.sv
package i2c_pkg;

    // --------------------
    // Bit level commands
    // --------------------
    typedef enum logic [1:0] {
        BIT_START = 2'd0,   // SDA falls under high SCL
        BIT_STOP  = 2'd1,   // SDA rises under high SCL
        BIT_WRITE = 2'd2,   // Drive one data bit
        BIT_READ  = 2'd3    // Release SDA and sample
    } bit_cmd_e;

    // Byte sequencer states
    typedef enum logic [3:0] {
        SEQ_IDLE      = 4'd0,
        SEQ_START     = 4'd1,
        SEQ_ADDR      = 4'd2,
        SEQ_ADDR_ACK  = 4'd3,
        SEQ_WRITE     = 4'd4,
        SEQ_WRITE_ACK = 4'd5,
        SEQ_READ      = 4'd6,
        SEQ_READ_NACK = 4'd7,
        SEQ_STOP      = 4'd8
    } seq_state_e;

    // --------------------
    // Bundles
    // --------------------
    typedef struct packed {
        logic       rw;         // 1 = read
        logic [7:0] wdata;      // Byte to write
    } i2c_req_t;

    typedef struct packed {
        logic [7:0] rdata;      // Byte read back
        logic       ack_error;  // Slave missed an ACK
    } i2c_rsp_t;

    typedef struct packed {
        bit_cmd_e cmd;
        logic     din;          // Bit to put on SDA
    } bit_req_t;

endpackage

//--- src/i2c_settings.svh
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// --------------------
// Bus timing
// --------------------
`define I2C_CLK_HZ 25_000_000            // System clock
`define I2C_SCL_HZ 100_000               // Standard mode SCL

// Four ticks per SCL period, 62 cycles each
`define I2C_QUARTER_DIV (`I2C_CLK_HZ / (4 * `I2C_SCL_HZ))

// --------------------
// Target device
// --------------------
`define I2C_DEV_ADDR 7'h48               // Fixed 7-bit slave address

`endif

//--- src/i2c_tick_gen.sv
`timescale 1ns/1ps
`include "i2c_settings.svh"

module i2c_tick_gen (
    input  logic clk,
    input  logic reset_n,
    input  logic tick_en,   // High while a bit command runs
    output logic tick       // Quarter SCL period pulse
);

    localparam logic [9:0] LAST = 10'(`I2C_QUARTER_DIV - 1);

    logic [9:0] cnt;  // Divider count

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (!tick_en) begin
            cnt  <= '0;                 // Restart phase on next enable
            tick <= 1'b0;
        end else if (cnt == LAST) begin
            cnt  <= '0;
            tick <= 1'b1;               // One cycle wide
        end else begin
            cnt  <= cnt + 10'd1;
            tick <= 1'b0;
        end
    end

    // No stray tick once the bit engine has gone idle
    a_tick_needs_en : assert property (@(posedge clk) disable iff (!reset_n)
        !$past(tick_en) |-> !tick);

endmodule

//--- tb.f
+incdir+src
src/i2c_pkg.sv
src/i2c_tick_gen.sv
src/i2c_bit_ctrl.sv
src/i2c_byte_ctrl.sv
src/i2c_master_top.sv
verification/i2c_clock_gen.sv
verification/i2c_slave_model.sv
verification/tb_i2c_master.sv

//--- verification/i2c_clock_gen.sv
`timescale 1ns/1ps

module i2c_clock_gen (
    output logic clk,
    output logic reset_n
);

    // 4 ns period, 250 MHz sim clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);      // Three cycles in reset
        reset_n <= 1'b1;
    end

endmodule

//--- verification/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h00
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       nack_addr,     // Refuse the address
    input  logic       preload,       // Load data_reg from preload_val
    input  logic [7:0] preload_val,
    output logic [7:0] data_reg,
    output logic [7:0] start_cnt,
    output logic [7:0] stop_cnt,
    output logic       write_seen,    // Pulse when a written byte lands
    input  wire        scl,           // Never stretched
    inout  wire        sda
);

    logic       scl_q;
    logic       sda_q;
    logic       drive_low;            // Open-drain SDA pull
    logic [3:0] bit_idx;              // SCL rises seen in this 9-bit slot
    logic       byte_no;              // 0 = address, 1 = data
    logic       in_txn;
    logic       addr_ok;
    logic       rd_mode;
    logic [7:0] shift;                // Incoming bits
    logic [7:0] tx;                   // Outgoing read bits
    logic       start_det;
    logic       stop_det;
    logic       scl_rise;
    logic       scl_fall;

    assign sda = drive_low ? 1'b0 : 1'bz;

    // Bus events, sampled on the system clock
    assign start_det = scl && scl_q && sda_q && !sda;
    assign stop_det  = scl && scl_q && !sda_q && sda;
    assign scl_rise  = scl && !scl_q;
    assign scl_fall  = !scl && scl_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            drive_low  <= 1'b0;
            bit_idx    <= '0;
            byte_no    <= 1'b0;
            in_txn     <= 1'b0;
            addr_ok    <= 1'b0;
            rd_mode    <= 1'b0;
            shift      <= '0;
            tx         <= '0;
            data_reg   <= '0;
            start_cnt  <= '0;
            stop_cnt   <= '0;
            write_seen <= 1'b0;
        end else begin
            scl_q      <= scl;
            sda_q      <= sda;
            write_seen <= 1'b0;
            if (preload) begin
                data_reg <= preload_val;
            end
            if (start_det) begin
                start_cnt <= start_cnt + 8'd1;
                in_txn    <= 1'b1;
                bit_idx   <= '0;
                byte_no   <= 1'b0;
                drive_low <= 1'b0;
            end else if (stop_det) begin
                stop_cnt  <= stop_cnt + 8'd1;
                in_txn    <= 1'b0;
                drive_low <= 1'b0;
            end else if (in_txn && scl_rise) begin
                if (bit_idx < 4'd8) begin
                    shift <= {shift[6:0], sda};     // MSB first
                end
                bit_idx <= bit_idx + 4'd1;
            end else if (in_txn && scl_fall) begin
                // --------------------
                // Next SDA value, set while SCL is low
                // --------------------
                if (bit_idx == 4'd8 && !byte_no) begin
                    addr_ok   <= (shift[7:1] == DEV_ADDR);
                    rd_mode   <= shift[0];
                    drive_low <= (shift[7:1] == DEV_ADDR) && !nack_addr;
                end else if (bit_idx == 4'd8) begin
                    drive_low <= addr_ok && !rd_mode;   // ACK a written byte
                    if (addr_ok && !rd_mode) begin
                        data_reg   <= shift;
                        write_seen <= 1'b1;
                    end
                end else if (bit_idx == 4'd9) begin
                    bit_idx <= '0;
                    byte_no <= 1'b1;
                    if (!byte_no && addr_ok && rd_mode) begin
                        drive_low <= ~data_reg[7];      // First read bit
                        tx        <= {data_reg[6:0], 1'b1};
                    end else begin
                        drive_low <= 1'b0;
                    end
                end else if (byte_no && addr_ok && rd_mode && bit_idx != 4'd0) begin
                    drive_low <= ~tx[7];
                    tx        <= {tx[6:0], 1'b1};
                end
            end
        end
    end

endmodule

//--- verification/tb_i2c_master.sv
`timescale 1ns/1ps
`include "i2c_settings.svh"

module tb_i2c_master;

    import i2c_pkg::*;

    // One-cycle check strobes
    typedef struct packed {
        logic idle;
        logic data;
        logic rdata;
        logic ack;
        logic cnt;
    } check_t;

    logic       clk;
    logic       reset_n;
    logic       load;
    i2c_req_t   req;
    logic       busy;
    i2c_rsp_t   rsp;
    wire        scl;
    wire        sda;
    logic       nack_addr;
    logic       preload;
    logic [7:0] preload_val;
    logic [7:0] slave_reg;
    logic [7:0] start_cnt;
    logic [7:0] stop_cnt;
    logic       write_seen;
    check_t     chk;
    logic [7:0] exp_byte;
    logic       exp_ack;
    logic [7:0] exp_starts;
    logic [7:0] exp_stops;
    logic [7:0] starts0;
    logic [7:0] stops0;
    logic [7:0] dbyte;
    logic [3:0] hi_edges;         // SDA edges under high SCL
    logic       scl_d;
    logic       sda_d;
    int         err_cnt = 0;
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    int         errs0;
    int         seed = 23168;
    int         cycles = 0;
    int         busy_cycles;

    pullup (scl);
    pullup (sda);

    i2c_clock_gen u_clk_gen (.clk(clk), .reset_n(reset_n));

    i2c_master_top uut (
        .clk(clk), .reset_n(reset_n), .load(load), .req(req),
        .busy(busy), .rsp(rsp), .scl(scl), .sda(sda)
    );

    i2c_slave_model #(.DEV_ADDR(`I2C_DEV_ADDR)) u_slave (
        .clk(clk), .reset_n(reset_n), .nack_addr(nack_addr), .preload(preload),
        .preload_val(preload_val), .data_reg(slave_reg), .start_cnt(start_cnt),
        .stop_cnt(stop_cnt), .write_seen(write_seen), .scl(scl), .sda(sda)
    );

    // --------------------
    // Monitors and watchdog
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_d       <= 1'b1;
            sda_d       <= 1'b1;
            hi_edges    <= '0;
            busy_cycles <= 0;
        end else begin
            scl_d       <= scl;
            sda_d       <= sda;
            busy_cycles <= busy ? busy_cycles + 1 : 0;
            if (load && !busy) begin
                hi_edges <= '0;                     // New transaction
            end else if (scl && scl_d && sda != sda_d) begin
                hi_edges <= hi_edges + 4'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == 40000) begin                 // Six transactions plus margin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_idle : assert property (@(posedge clk) disable iff (!reset_n)
        chk.idle |-> (!busy && rsp == '0 && scl && sda))
        else begin
            $display("ERROR busy/rsp/scl/sda got %h %h %h %h expected 0 000 1 1",
                     busy, rsp, scl, sda);
            err_cnt = err_cnt + 1;
        end

    a_slave_reg : assert property (@(posedge clk) disable iff (!reset_n)
        chk.data |-> slave_reg == exp_byte)
        else begin
            $display("ERROR slave_reg got %h expected %h", slave_reg, exp_byte);
            err_cnt = err_cnt + 1;
        end

    a_rdata : assert property (@(posedge clk) disable iff (!reset_n)
        chk.rdata |-> rsp.rdata == exp_byte)
        else begin
            $display("ERROR rsp.rdata got %h expected %h", rsp.rdata, exp_byte);
            err_cnt = err_cnt + 1;
        end

    a_ack : assert property (@(posedge clk) disable iff (!reset_n)
        chk.ack |-> rsp.ack_error == exp_ack)
        else begin
            $display("ERROR rsp.ack_error got %h expected %h", rsp.ack_error, exp_ack);
            err_cnt = err_cnt + 1;
        end

    a_starts : assert property (@(posedge clk) disable iff (!reset_n)
        chk.cnt |-> start_cnt == exp_starts)
        else begin
            $display("ERROR start_cnt got %h expected %h", start_cnt, exp_starts);
            err_cnt = err_cnt + 1;
        end

    a_stops : assert property (@(posedge clk) disable iff (!reset_n)
        chk.cnt |-> stop_cnt == exp_stops)
        else begin
            $display("ERROR stop_cnt got %h expected %h", stop_cnt, exp_stops);
            err_cnt = err_cnt + 1;
        end

    // Only START and STOP may move SDA under high SCL
    a_hi_edges : assert property (@(posedge clk) disable iff (!reset_n)
        chk.cnt |-> hi_edges == 4'd2)
        else begin
            $display("ERROR hi_edges got %h expected %h", hi_edges, 4'd2);
            err_cnt = err_cnt + 1;
        end

    a_busy_bound : assert property (@(posedge clk) disable iff (!reset_n)
        busy |-> busy_cycles < 6000)
        else begin
            $display("busy stayed high for more than 6000 cycles");
            err_cnt = err_cnt + 1;
        end

    a_no_write : assert property (@(posedge clk) disable iff (!reset_n)
        write_seen |-> !nack_addr)
        else begin
            $display("The slave took a data byte while refusing its address");
            err_cnt = err_cnt + 1;
        end

    // --------------------
    // Stimulus tasks
    // --------------------
    task automatic run_txn(input logic rw, input logic [7:0] wdata, input logic extra_load);
        @(posedge clk);
        load <= 1'b1;
        req  <= '{rw: rw, wdata: wdata};
        @(posedge clk);
        load <= 1'b0;
        if (extra_load) begin
            repeat (200) @(posedge clk);            // Still in the START bit
            load <= 1'b1;
            req  <= '{rw: 1'b1, wdata: ~wdata};
            @(posedge clk);
            load <= 1'b0;
        end
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
    endtask

    task automatic preload_slave(input logic [7:0] val);
        @(posedge clk);
        preload     <= 1'b1;
        preload_val <= val;
        @(posedge clk);
        preload <= 1'b0;
    endtask

    task automatic fire_checks(input check_t c, input logic [7:0] b, input logic a,
                               input logic [7:0] s, input logic [7:0] p);
        @(posedge clk);
        chk        <= c;
        exp_byte   <= b;
        exp_ack    <= a;
        exp_starts <= s;
        exp_stops  <= p;
        @(posedge clk);
        chk <= '0;
        repeat (2) @(posedge clk);                  // Gap before the next test
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt = pass_cnt + 1;
            $display("%s: pass", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("%s: FAIL", name);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        load        <= 1'b0;
        req         <= '0;
        nack_addr   <= 1'b0;
        preload     <= 1'b0;
        preload_val <= '0;
        chk         <= '0;
        exp_byte    <= '0;
        exp_ack     <= 1'b0;
        exp_starts  <= '0;
        exp_stops   <= '0;
        @(posedge reset_n);
        repeat (2) @(posedge clk);

        errs0 = err_cnt;
        fire_checks('{idle: 1'b1, default: 1'b0}, 8'h00, 1'b0, 8'h00, 8'h00);
        report("test 1 reset state", errs0);

        errs0   = err_cnt;
        starts0 = start_cnt;
        stops0  = stop_cnt;
        dbyte   = 8'($random(seed));
        run_txn(1'b0, dbyte, 1'b0);
        fire_checks('{data: 1'b1, ack: 1'b1, cnt: 1'b1, default: 1'b0}, dbyte, 1'b0,
                    starts0 + 8'd1, stops0 + 8'd1);
        report("test 2 write", errs0);

        errs0   = err_cnt;
        dbyte   = 8'($random(seed));
        preload_slave(dbyte);
        starts0 = start_cnt;
        stops0  = stop_cnt;
        run_txn(1'b1, 8'h00, 1'b0);
        fire_checks('{rdata: 1'b1, ack: 1'b1, cnt: 1'b1, default: 1'b0}, dbyte, 1'b0,
                    starts0 + 8'd1, stops0 + 8'd1);
        report("test 3 read", errs0);

        // Refused address leaves the register as it was
        errs0   = err_cnt;
        dbyte   = slave_reg;
        starts0 = start_cnt;
        stops0  = stop_cnt;
        nack_addr <= 1'b1;
        run_txn(1'b0, ~dbyte, 1'b0);
        fire_checks('{data: 1'b1, ack: 1'b1, cnt: 1'b1, default: 1'b0}, dbyte, 1'b1,
                    starts0 + 8'd1, stops0 + 8'd1);
        nack_addr <= 1'b0;
        report("test 4 address nack", errs0);

        errs0   = err_cnt;
        starts0 = start_cnt;
        stops0  = stop_cnt;
        dbyte   = 8'($random(seed));
        run_txn(1'b0, dbyte, 1'b1);                 // Second load lands while busy
        fire_checks('{data: 1'b1, ack: 1'b1, cnt: 1'b1, default: 1'b0}, dbyte, 1'b0,
                    starts0 + 8'd1, stops0 + 8'd1);
        report("test 5 load while busy", errs0);

        errs0   = err_cnt;
        starts0 = start_cnt;
        stops0  = stop_cnt;
        dbyte   = 8'($random(seed));
        run_txn(1'b0, dbyte, 1'b0);
        fire_checks('{data: 1'b1, ack: 1'b1, cnt: 1'b1, default: 1'b0}, dbyte, 1'b0,
                    starts0 + 8'd1, stops0 + 8'd1);
        run_txn(1'b1, 8'h00, 1'b0);
        fire_checks('{rdata: 1'b1, ack: 1'b1, cnt: 1'b1, default: 1'b0}, dbyte, 1'b0,
                    starts0 + 8'd2, stops0 + 8'd2);
        report("test 6 write then read", errs0);

        $display("Summary: %0d tests passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
